//--- sha1_msg_pad_top.f
verilog/sha1_pad_pkg.sv
verilog/msg_fetch.sv
verilog/pad_word_gen.sv
verilog/block_packer.sv
verilog/sha1_msg_pad_top.sv
tb/tb_clock_gen.sv
tb/tb_sha1_msg_pad.sv

//--- tb/tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen (
    output logic sys_clk,
    output logic sys_rst
);
    localparam int HALF_PERIOD  = 50;   // 100 ns clock period.
    localparam int RESET_CYCLES = 2;

    initial begin
        sys_clk = 1'b0;
        forever #HALF_PERIOD sys_clk = ~sys_clk;
    end

    initial begin
        sys_rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge sys_clk);
        sys_rst <= 1'b0;
    end

endmodule

//--- tb/tb_sha1_msg_pad.sv
`timescale 1ns/1ns

module tb_sha1_msg_pad;
    import sha1_pad_pkg::*;

    localparam int          NUM_MSGS  = 11;
    localparam int          INFO_SIZE = 16;
    localparam int          DATA_SIZE = 64;
    localparam logic [31:0] SEED      = 32'h151e_abfa;

    typedef struct packed {
        logic [LEN_W-1:0]  len;
        logic [CHAN_W-1:0] chan;
        logic [7:0]        stall;    // Cycles with chan_ready low after queuing.
        logic [7:0]        blocks;   // Expected number of blocks.
    } msg_case_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Message table with length, channel, stall and blocks.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    msg_case_t cases [NUM_MSGS] = '{
        {16'd0,   6'd3,  8'd0,  8'd1},
        {16'd1,   6'd17, 8'd0,  8'd1},
        {16'd15,  6'd42, 8'd0,  8'd1},
        {16'd16,  6'd0,  8'd25, 8'd1},
        {16'd55,  6'd63, 8'd0,  8'd1},
        {16'd56,  6'd8,  8'd0,  8'd2},
        {16'd63,  6'd21, 8'd0,  8'd2},
        {16'd64,  6'd5,  8'd40, 8'd2},
        {16'd119, 6'd33, 8'd0,  8'd2},
        {16'd120, 6'd12, 8'd0,  8'd3},
        {16'd200, 6'd50, 8'd0,  8'd4}
    };

    logic              sys_clk;
    logic              sys_rst;
    logic              chan_ready;
    logic              info_empty;
    msg_info_t         info;
    logic              info_rd_en;
    logic [WORD_W-1:0] data_word;
    logic              data_rd_en;
    block_out_t        blk_out;

    msg_info_t         info_mem [INFO_SIZE];
    logic [WORD_W-1:0] data_mem [DATA_SIZE];
    int                word_base [NUM_MSGS];   // First data word of each message.
    int                info_rd_ptr    = 0;
    int                info_wr_ptr    = 0;
    int                data_rd_ptr    = 0;
    int                data_fill      = 0;
    logic [31:0]       rng_state      = SEED;
    int                cycle          = 0;
    int                cur_msg        = 0;
    int                cur_blk        = 0;
    int                last_blk_cycle = 0;
    msg_case_t         row;

    tb_clock_gen clock_gen (
        .sys_clk (sys_clk),
        .sys_rst (sys_rst)
    );

    sha1_msg_pad_top uut (
        .sys_clk    (sys_clk),
        .sys_rst    (sys_rst),
        .chan_ready (chan_ready),
        .info_empty (info_empty),
        .info       (info),
        .info_rd_en (info_rd_en),
        .data_word  (data_word),
        .data_rd_en (data_rd_en),
        .blk_out    (blk_out)
    );

    task automatic check(input logic [BLOCK_W-1:0] actual, input logic [BLOCK_W-1:0] expected,
                         input string what);
        if (actual !== expected) begin
            $display("[ERROR] %0t ns: %s mismatch, got %0h, expected %0h",
                     $time, what, actual, expected);
            $display("TESTS FAILED");
            $fatal(1, "Stopped at the first mismatch.");
        end
    endtask

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Message bytes, then 0x80, zeros, and the bit length in the last 8 bytes.
    function automatic logic [BLOCK_W-1:0] expected_block(input int m, input int b);
        logic [BLOCK_W-1:0]     blk;
        logic [LEN_FIELD_W-1:0] bit_len;
        logic [7:0]             val;
        int                     len;
        int                     total;
        int                     idx;
        len     = cases[m].len;
        total   = cases[m].blocks * 64;
        bit_len = len;
        bit_len = bit_len << 3;
        for (int k = 0; k < 64; k++) begin
            idx = 64 * b + k;
            if (idx < len) begin
                val = data_mem[word_base[m] + idx / 16][WORD_W-1-8*(idx % 16) -: 8];
            end else if (idx == len) begin
                val = 8'h80;
            end else if (idx >= total - 8) begin
                val = bit_len[8*(total-1-idx) +: 8];
            end else begin
                val = 8'h00;
            end
            blk[BLOCK_W-1-8*k -: 8] = val;
        end
        return blk;
    endfunction

    // Random bytes fill every word, including the bytes past the message end.
    task automatic load_message(input int m);
        int                nwords;
        logic [WORD_W-1:0] w;
        nwords       = (cases[m].len + 15) / 16;
        word_base[m] = data_fill;
        for (int n = 0; n < nwords; n++) begin
            for (int q = 0; q < 4; q++) begin
                rng_state = xorshift(rng_state);
                w         = {w[WORD_W-33:0], rng_state};
            end
            data_mem[data_fill] = w;
            data_fill++;
        end
        info_mem[m] = {cases[m].len, cases[m].chan};
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // FIFO models with one cycle of read latency.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always @(posedge sys_clk) begin
        check(info_rd_en && !chan_ready, 1'b0, "info read while chan_ready low");
        if (info_rd_en) begin
            info        <= info_mem[info_rd_ptr];
            info_rd_ptr <= info_rd_ptr + 1;
        end
        if (data_rd_en) begin
            data_word   <= data_mem[data_rd_ptr];
            data_rd_ptr <= data_rd_ptr + 1;
        end
        info_empty <= (info_wr_ptr == info_rd_ptr + (info_rd_en ? 1 : 0));
        cycle      <= cycle + 1;
    end

    // Block monitor sampled away from the rising edge.
    always @(negedge sys_clk) begin
        if (!sys_rst && blk_out.valid) begin
            check(cur_msg < NUM_MSGS, 1'b1, "block after the last message");
            row = cases[cur_msg];
            check(blk_out.data, expected_block(cur_msg, cur_blk), "block data");
            check(blk_out.sop, cur_blk == 0, "sop");
            check(blk_out.eop, cur_blk == row.blocks - 1, "eop");
            check(blk_out.tag, cur_msg, "tag");
            check(blk_out.addr, {row.chan, cur_blk[BLK_IDX_W-1:0]}, "address");
            if (cur_blk != 0) begin
                check(cycle - last_blk_cycle, 4, "block spacing");
            end
            last_blk_cycle = cycle;
            if (cur_blk == row.blocks - 1) begin
                cur_msg++;
                cur_blk = 0;
            end else begin
                cur_blk++;
            end
        end
    end

    initial begin
        chan_ready = 1'b0;
        info_empty = 1'b1;
        info       = '0;
        data_word  = '0;
        @(posedge sys_clk);
        while (sys_rst) @(posedge sys_clk);
        chan_ready <= 1'b1;
        for (int i = 0; i < NUM_MSGS; i++) begin
            load_message(i);
            @(posedge sys_clk);
            info_wr_ptr <= i + 1;
            if (cases[i].stall != 0) begin
                chan_ready <= 1'b0;   // Queued messages must wait here.
                repeat (cases[i].stall) @(posedge sys_clk);
                chan_ready <= 1'b1;
            end
        end
        while (cur_msg < NUM_MSGS) @(posedge sys_clk);
        repeat (20) @(posedge sys_clk);   // Catch any stray block.
        check(info_rd_ptr, NUM_MSGS, "info read count");
        check(data_rd_ptr, data_fill, "data read count");
        $display("TESTS PASSED");
        $finish;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Watchdog.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin : watchdog
        int limit;
        limit = 100;
        for (int i = 0; i < NUM_MSGS; i++) begin
            limit += 8 * WORDS_PER_BLOCK * cases[i].blocks;
        end
        repeat (limit) @(posedge sys_clk);
        $display("Watchdog expired: blocks stopped arriving after %0d of %0d messages.",
                 cur_msg, NUM_MSGS);
        $display("TESTS FAILED");
        $fatal(1, "Simulation timed out.");
    end

endmodule

//--- verilog/block_packer.sv
`timescale 1ns/1ns

module block_packer (
    input  logic                            sys_clk,
    input  logic                            sys_rst,
    input  logic [sha1_pad_pkg::CHAN_W-1:0] chan,
    input  sha1_pad_pkg::msg_word_t         word_in,
    output sha1_pad_pkg::block_out_t        blk_out
);
    import sha1_pad_pkg::*;

    logic [BLK_WORD_W-1:0]       word_cnt;
    logic [BLOCK_W-WORD_W-1:0]   head;        // Words gathered so far, oldest on top.
    logic [BLK_IDX_W-1:0]        blk_idx;
    logic [TAG_W-1:0]            tag_cnt;
    logic                        first_blk;
    logic                        blk_done;

    assign blk_done = word_in.valid && (word_cnt == BLK_WORD_W'(WORDS_PER_BLOCK - 1));

    always_ff @(posedge sys_clk) begin
        if (word_in.valid) begin
            head <= {head[BLOCK_W-2*WORD_W-1:0], word_in.data};
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Block output with flags, tag and address.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge sys_clk) begin
        if (sys_rst) begin
            word_cnt      <= '0;
            blk_idx       <= '0;
            tag_cnt       <= '0;
            first_blk     <= 1'b1;
            blk_out.valid <= 1'b0;
            blk_out.sop   <= 1'b0;
            blk_out.eop   <= 1'b0;
            blk_out.tag   <= '0;
        end else begin
            blk_out.valid <= blk_done;
            blk_out.sop   <= blk_done && first_blk;
            blk_out.eop   <= blk_done && word_in.last;   // Last word always closes a block.
            if (blk_done) begin
                word_cnt <= '0;
            end else if (word_in.valid) begin
                word_cnt <= word_cnt + 1'b1;
            end
            if (blk_done) begin
                blk_out.data <= {head, word_in.data};
                blk_out.tag  <= tag_cnt;
                blk_out.addr <= {chan, blk_idx};
                if (word_in.last) begin
                    blk_idx   <= '0;
                    tag_cnt   <= tag_cnt + 1'b1;   // One tag per message.
                    first_blk <= 1'b1;
                end else begin
                    blk_idx   <= blk_idx + 1'b1;
                    first_blk <= 1'b0;
                end
            end
        end
    end

endmodule

//--- verilog/msg_fetch.sv
`timescale 1ns/1ns

module msg_fetch (
    input  logic                            sys_clk,
    input  logic                            sys_rst,
    input  logic                            chan_ready,
    input  logic                            info_empty,
    input  sha1_pad_pkg::msg_info_t         info,
    output logic                            info_rd_en,
    input  logic [sha1_pad_pkg::WORD_W-1:0] data_word,
    output logic                            data_rd_en,
    input  logic                            pad_busy,
    output sha1_pad_pkg::msg_start_t        start,
    output sha1_pad_pkg::msg_word_t         word_out,
    output logic [sha1_pad_pkg::CHAN_W-1:0] chan
);
    import sha1_pad_pkg::*;

    fetch_state_t      state;
    logic [WCNT_W-1:0] info_words;   // Data words in the message now on the info port.
    logic [WCNT_W-1:0] rd_left;
    logic              rd_last;
    logic              rd_d1;
    logic              rd_last_d1;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Read requests.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign info_words = WCNT_W'(info.len[LEN_W-1:4]) + WCNT_W'(|info.len[3:0]);

    // A new message only starts once the padder has finished the previous one.
    assign info_rd_en = (state == FETCH_IDLE) && !info_empty && chan_ready && !pad_busy;

    // The info word is valid in WAIT_INFO, so the first data read goes out in the same cycle.
    assign data_rd_en = ((state == FETCH_WAIT_INFO) && (info_words != '0)) ||
                        (state == FETCH_READ);

    assign rd_last = (state == FETCH_WAIT_INFO) ? (info_words == WCNT_W'(1)) :
                                                  (rd_left == WCNT_W'(1));

    always_ff @(posedge sys_clk) begin
        if (sys_rst) begin
            state      <= FETCH_IDLE;
            rd_left    <= '0;
            rd_d1      <= 1'b0;
            rd_last_d1 <= 1'b0;
        end else begin
            rd_d1      <= data_rd_en;
            rd_last_d1 <= data_rd_en && rd_last;
            case (state)
                FETCH_IDLE: begin
                    if (info_rd_en) begin
                        state <= FETCH_WAIT_INFO;
                    end
                end
                FETCH_WAIT_INFO: begin
                    rd_left <= info_words - 1'b1;   // Reads still due after this one.
                    if (info_words > WCNT_W'(1)) begin
                        state <= FETCH_READ;
                    end else begin
                        state <= FETCH_IDLE;
                    end
                end
                FETCH_READ: begin
                    rd_left <= rd_left - 1'b1;
                    if (rd_left == WCNT_W'(1)) begin
                        state <= FETCH_IDLE;
                    end
                end
                default: state <= FETCH_IDLE;
            endcase
        end
    end

    // Channel stays put until the next message is fetched.
    always_ff @(posedge sys_clk) begin
        if (state == FETCH_WAIT_INFO) begin
            chan <= info.chan;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Outputs to the padder.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign start = '{strobe: (state == FETCH_WAIT_INFO), info: info};

    // FIFO data shows up one cycle after its read, matching the delayed flags.
    assign word_out = '{valid: rd_d1, last: rd_last_d1, data: data_word};

endmodule

//--- verilog/pad_word_gen.sv
`timescale 1ns/1ns

module pad_word_gen (
    input  logic                     sys_clk,
    input  logic                     sys_rst,
    input  sha1_pad_pkg::msg_start_t start,
    input  sha1_pad_pkg::msg_word_t  word_in,
    output logic                     pad_busy,
    output sha1_pad_pkg::msg_word_t  word_out
);
    import sha1_pad_pkg::*;

    pad_state_t             state;
    logic [LEN_W-1:0]       len_q;
    logic [WCNT_W-1:0]      new_blocks;
    logic [WCNT_W-1:0]      new_total;
    logic [WCNT_W-1:0]      new_data;
    logic [WCNT_W-1:0]      new_fill;
    logic [WCNT_W-1:0]      fill_left;    // Fill words still to emit.
    logic                   fill_first;
    logic                   tail_part;
    logic [LEN_FIELD_W-1:0] bit_len;
    logic [WORD_W-1:0]      tail_word;
    logic [WORD_W-1:0]      fill_word;
    logic                   out_valid;
    logic                   out_last;
    logic [WORD_W-1:0]      out_data;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Word counts of the starting message.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign new_blocks = WCNT_W'(start.info.len[LEN_W-1:6]) +
                        ((start.info.len[5:0] > SHORT_TAIL_MAX) ? WCNT_W'(2) : WCNT_W'(1));
    assign new_total  = WCNT_W'(new_blocks * WORDS_PER_BLOCK);
    assign new_data   = WCNT_W'(start.info.len[LEN_W-1:4]) + WCNT_W'(|start.info.len[3:0]);
    assign new_fill   = new_total - new_data;

    assign tail_part = |len_q[3:0];   // Last data word is only partly filled.
    assign bit_len   = LEN_FIELD_W'({len_q, 3'b000});

    assign pad_busy = start.strobe || (state != PAD_IDLE);

    // Clear the bytes past the end and drop the marker right after the last byte.
    always_comb begin
        tail_word = word_in.data;
        if (tail_part) begin
            for (int b = 0; b < BYTES_PER_WORD; b++) begin
                if (b == len_q[3:0]) begin
                    tail_word[WORD_W-1-8*b -: 8] = PAD_MARK;
                end else if (b > len_q[3:0]) begin
                    tail_word[WORD_W-1-8*b -: 8] = 8'h00;
                end
            end
        end
        if (fill_left == '0) begin
            tail_word[LEN_FIELD_W-1:0] = bit_len;   // No fill words, length goes here.
        end
    end

    always_comb begin
        fill_word = '0;
        if (fill_first && !tail_part) begin
            fill_word[WORD_W-1 -: 8] = PAD_MARK;
        end
        if (fill_left == WCNT_W'(1)) begin
            fill_word[LEN_FIELD_W-1:0] = bit_len;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Padding FSM.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge sys_clk) begin
        if (sys_rst) begin
            state      <= PAD_IDLE;
            fill_left  <= '0;
            fill_first <= 1'b0;
            out_valid  <= 1'b0;
            out_last   <= 1'b0;
        end else begin
            out_valid <= 1'b0;
            out_last  <= 1'b0;
            case (state)
                PAD_IDLE: begin
                    if (start.strobe) begin
                        if (start.info.len == '0) begin
                            // Empty message: the marker word goes out straight away.
                            out_valid  <= 1'b1;
                            fill_left  <= new_fill - 1'b1;
                            fill_first <= 1'b0;
                            state      <= PAD_FILL;
                        end else begin
                            fill_left <= new_fill;
                            state     <= PAD_DATA;
                        end
                    end
                end
                PAD_DATA: begin
                    if (word_in.valid) begin
                        out_valid <= 1'b1;
                        if (word_in.last) begin
                            fill_first <= 1'b1;
                            if (fill_left == '0) begin
                                out_last <= 1'b1;
                                state    <= PAD_IDLE;
                            end else begin
                                state <= PAD_FILL;
                            end
                        end
                    end
                end
                PAD_FILL: begin
                    out_valid  <= 1'b1;
                    fill_first <= 1'b0;
                    fill_left  <= fill_left - 1'b1;
                    if (fill_left == WCNT_W'(1)) begin
                        out_last <= 1'b1;
                        state    <= PAD_IDLE;
                    end
                end
                default: state <= PAD_IDLE;
            endcase
        end
    end

    always_ff @(posedge sys_clk) begin
        if ((state == PAD_IDLE) && start.strobe) begin
            len_q <= start.info.len;
        end
        case (state)
            PAD_IDLE: out_data <= {PAD_MARK, {(WORD_W-8){1'b0}}};
            PAD_DATA: out_data <= word_in.last ? tail_word : word_in.data;
            default:  out_data <= fill_word;
        endcase
    end

    assign word_out = '{valid: out_valid, last: out_last, data: out_data};

endmodule

//--- verilog/sha1_msg_pad_top.sv
`timescale 1ns/1ns

module sha1_msg_pad_top (
    input  logic                            sys_clk,
    input  logic                            sys_rst,
    input  logic                            chan_ready,
    input  logic                            info_empty,
    input  sha1_pad_pkg::msg_info_t         info,
    output logic                            info_rd_en,
    input  logic [sha1_pad_pkg::WORD_W-1:0] data_word,
    output logic                            data_rd_en,
    output sha1_pad_pkg::block_out_t        blk_out
);
    import sha1_pad_pkg::*;

    msg_start_t        start;
    msg_word_t         data_stream;   // Raw message words from the data FIFO.
    msg_word_t         pad_stream;
    logic              pad_busy;
    logic [CHAN_W-1:0] chan;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Fetch, pad, pack.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    msg_fetch u_msg_fetch (
        .sys_clk    (sys_clk),
        .sys_rst    (sys_rst),
        .chan_ready (chan_ready),
        .info_empty (info_empty),
        .info       (info),
        .info_rd_en (info_rd_en),
        .data_word  (data_word),
        .data_rd_en (data_rd_en),
        .pad_busy   (pad_busy),
        .start      (start),
        .word_out   (data_stream),
        .chan       (chan)
    );

    pad_word_gen u_pad_word_gen (
        .sys_clk  (sys_clk),
        .sys_rst  (sys_rst),
        .start    (start),
        .word_in  (data_stream),
        .pad_busy (pad_busy),
        .word_out (pad_stream)
    );

    block_packer u_block_packer (
        .sys_clk (sys_clk),
        .sys_rst (sys_rst),
        .chan    (chan),
        .word_in (pad_stream),
        .blk_out (blk_out)
    );

endmodule

//--- verilog/sha1_pad_pkg.sv
package sha1_pad_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Widths and constants.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int WORD_W          = 128;
    localparam int BLOCK_W         = 512;
    localparam int WORDS_PER_BLOCK = 4;
    localparam int LEN_W           = 16;
    localparam int CHAN_W          = 6;
    localparam int TAG_W           = 14;
    localparam int BLK_IDX_W       = 6;    // Block index wraps modulo 64.
    localparam int LEN_FIELD_W     = 64;
    localparam int ADDR_W          = CHAN_W + BLK_IDX_W;
    localparam int BYTES_PER_WORD  = WORD_W / 8;
    localparam int BLK_WORD_W      = $clog2(WORDS_PER_BLOCK);

    // Word counter width, large enough for the padded word count of the longest message.
    localparam int WCNT_W          = LEN_W - 3;

    // Largest byte offset in a block that still leaves room for 0x80 and the length field.
    localparam int SHORT_TAIL_MAX  = 55;

    localparam logic [7:0] PAD_MARK = 8'h80;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Types.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef struct packed {
        logic [LEN_W-1:0]  len;   // Byte length of the message.
        logic [CHAN_W-1:0] chan;
    } msg_info_t;

    typedef struct packed {
        logic      strobe;
        msg_info_t info;
    } msg_start_t;

    typedef struct packed {
        logic              valid;
        logic              last;
        logic [WORD_W-1:0] data;
    } msg_word_t;

    typedef enum logic [1:0] {
        PAD_IDLE,
        PAD_DATA,
        PAD_FILL
    } pad_state_t;

    typedef enum logic [1:0] {
        FETCH_IDLE,
        FETCH_WAIT_INFO,
        FETCH_READ
    } fetch_state_t;

    typedef struct packed {
        logic               valid;
        logic               sop;
        logic               eop;
        logic [BLOCK_W-1:0] data;
        logic [TAG_W-1:0]   tag;
        logic [ADDR_W-1:0]  addr;   // Channel in the top bits, block index below.
    } block_out_t;

endpackage
